// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

echo "$out" | grep -q "All checks passed"

// ==== src/lfps_pkg.sv ====
/* LFPS kind and transmit and receive FSM encodings */
`default_nettype none

package lfps_pkg;

	// burst kinds the controller may ask for
	typedef enum logic {POLL, U1_EXIT} lfps_kind_t;

	// transmit FSM
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_BURST,
		TX_GAP,
		TX_DONE
	} lfps_tx_state_t;

	// receive FSM
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_BURST
	} lfps_rx_state_t;

endpackage

`default_nettype wire

// ==== src/lfps_rx.sv ====
/* rx electrical idle synchronizer and LFPS burst classifier */
`default_nettype none
`include "ltssm_consts.svh"

module lfps_rx (
	input  logic slow_clk,
	input  logic hot_reset,
	input  logic port_rx_elecidle,
	input  logic lfps_rx_enable,
	output logic lfps_recv_poll,
	output logic lfps_recv_u1_exit
);
	import lfps_pkg::*;

	logic                    eidle_meta;
	logic                    eidle_sync;
	lfps_rx_state_t          rx_state;
	// low cycles of the current burst
	logic [`DELAY_WIDTH-1:0] burst_cnt;
	// cycles since the last burst start
	logic [`DELAY_WIDTH-1:0] start_cnt;
	// start-to-start spacing of the current burst
	logic [`DELAY_WIDTH-1:0] start_gap;
	// previous burst was a polling burst
	logic                    poll_prev;

	// two-flop synchronizer, idles high
	always_ff @(posedge slow_clk) begin
		if (hot_reset) begin
			eidle_meta <= 1'b1;
			eidle_sync <= 1'b1;
		end else begin
			eidle_meta <= port_rx_elecidle;
			eidle_sync <= eidle_meta;
		end
	end

	// burst length and spacing counters, both saturate
	always_ff @(posedge slow_clk) begin
		if (~&start_cnt)
			start_cnt <= start_cnt + 1'b1;
		if (rx_state == RX_IDLE && !eidle_sync) begin
			burst_cnt <= 1;
			start_gap <= start_cnt;
			start_cnt <= 1;
		end else if (!eidle_sync && ~&burst_cnt) begin
			burst_cnt <= burst_cnt + 1'b1;
		end
	end

	always_ff @(posedge slow_clk) begin
		// disabled drops the history, so polling needs two fresh bursts
		if (hot_reset || !lfps_rx_enable) begin
			rx_state <= RX_IDLE;
			poll_prev <= 1'b0;
			lfps_recv_poll <= 1'b0;
			lfps_recv_u1_exit <= 1'b0;
		end else begin
			lfps_recv_poll <= 1'b0;
			lfps_recv_u1_exit <= 1'b0;
			case (rx_state)
			RX_IDLE: begin
				if (!eidle_sync)
					rx_state <= RX_BURST;
			end
			RX_BURST: begin
				// u1 exit fires while the burst is still on
				if (!eidle_sync && burst_cnt == (`U1_EXIT_RX_MIN - 1))
					lfps_recv_u1_exit <= 1'b1;
				if (eidle_sync) begin
					rx_state <= RX_IDLE;
					if (burst_cnt >= `POLL_RX_MIN && burst_cnt < `POLL_RX_MAX) begin
						poll_prev <= 1'b1;
						if (poll_prev && start_gap >= `POLL_GAP_MIN &&
							start_gap < `POLL_GAP_MAX)
							lfps_recv_poll <= 1'b1;
					end else begin
						poll_prev <= 1'b0;
					end
				end
			end
			default: rx_state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/lfps_tx.sv ====
/* LFPS burst generator, one burst and its gap per four-phase request */
`default_nettype none
`include "ltssm_consts.svh"

module lfps_tx (
	input  logic                 slow_clk,
	input  logic                 hot_reset,
	input  logic                 lfps_send_req,
	input  lfps_pkg::lfps_kind_t lfps_send_kind,
	output logic                 lfps_send_ack,
	output logic                 port_tx_elecidle
);
	import lfps_pkg::*;

	lfps_tx_state_t          tx_state;
	logic [`DELAY_WIDTH-1:0] cnt;
	logic [`DELAY_WIDTH-1:0] burst_len;
	logic [`DELAY_WIDTH-1:0] period_len;

	// shape of the burst, taken while idle so it is ready at the request
	always_ff @(posedge slow_clk) begin
		if (tx_state == TX_IDLE) begin
			cnt <= 1;
			if (lfps_send_kind == POLL) begin
				burst_len <= `LFPS_POLL_BURST;
				period_len <= `LFPS_POLL_PERIOD;
			end else begin
				burst_len <= `LFPS_U1_EXIT_BURST;
				period_len <= `LFPS_U1_EXIT_PERIOD;
			end
		end else begin
			// cycles since the request was seen
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge slow_clk) begin
		if (hot_reset) begin
			tx_state <= TX_IDLE;
			lfps_send_ack <= 1'b0;
			port_tx_elecidle <= 1'b1;
		end else begin
			case (tx_state)
			TX_IDLE: begin
				// burst starts on the next cycle
				if (lfps_send_req) begin
					port_tx_elecidle <= 1'b0;
					tx_state <= TX_BURST;
				end
			end
			TX_BURST: begin
				if (cnt == burst_len) begin
					port_tx_elecidle <= 1'b1;
					tx_state <= TX_GAP;
				end
			end
			TX_GAP: begin
				// ack marks the end of the full period
				if (cnt == period_len) begin
					lfps_send_ack <= 1'b1;
					tx_state <= TX_DONE;
				end
			end
			TX_DONE: begin
				// hold ack until the request goes away
				if (!lfps_send_req) begin
					lfps_send_ack <= 1'b0;
					tx_state <= TX_IDLE;
				end
			end
			default: tx_state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/ltssm_consts.svh ====
/* timeouts, LFPS burst shapes, receive windows and count limits,
   all scaled to slow_clk cycles */
`ifndef LTSSM_CONSTS_SVH
`define LTSSM_CONSTS_SVH

// LFPS transmit, burst length and full period
`define LFPS_POLL_BURST      4
`define LFPS_POLL_PERIOD     16
`define LFPS_U1_EXIT_BURST   10
`define LFPS_U1_EXIT_PERIOD  14

// receive windows, burst length is [min, max)
`define POLL_RX_MIN          3
`define POLL_RX_MAX          6
// start-to-start spacing of two polling bursts
`define POLL_GAP_MIN         10
`define POLL_GAP_MAX         24
`define U1_EXIT_RX_MIN       9

// receiver detection
`define RX_DETECT_QUIET      20
`define RX_DETECT_TRIES      8

// polling exit thresholds
`define POLL_SENT_MIN        16
`define POLL_RECV_MIN        2
`define POLL_SENT_AFTER_RECV 4

// training steps
`define TS_RECV_COUNT        8
`define TS2_SEND_CYCLES      32
`define T_POLLING_LFPS       600
`define T_TRAIN_STEP         200

`define DELAY_WIDTH          12

`endif

// ==== src/ltssm_ctrl.sv ====
/* link training FSM: receiver detect, polling, training, U0/U1, recovery,
   with its counters and the four-phase power handshake */
`default_nettype none
`include "ltssm_consts.svh"

module ltssm_ctrl (
	input  logic                    slow_clk,
	input  logic                    hot_reset,
	input  logic                    partner_looking,
	input  logic                    partner_detected,
	input  logic                    port_power_ack,
	input  logic                    train_ts1,
	input  logic                    train_ts2,
	input  logic                    train_idle_pass,
	input  logic                    go_disabled,
	input  logic                    go_recovery,
	input  logic                    go_u1,
	input  logic                    lfps_send_ack,
	input  logic                    lfps_recv_poll,
	input  logic                    lfps_recv_u1_exit,
	output logic                    partner_detect,
	output logic                    port_power_req,
	output ltssm_pkg::power_down_t  port_power_down,
	output logic                    train_active,
	output logic                    train_config,
	output logic                    train_idle,
	output logic                    lfps_send_req,
	output lfps_pkg::lfps_kind_t    lfps_send_kind,
	output logic                    lfps_rx_enable,
	output ltssm_pkg::ltssm_state_t ltssm_state
);
	import ltssm_pkg::*;
	import lfps_pkg::*;

	// time in the current state
	logic [`DELAY_WIDTH-1:0] dc;
	// TS received
	logic [3:0]              tc;
	// TS2 send cycles
	logic [5:0]              tsc;
	logic [3:0]              rx_tries;
	logic [4:0]              poll_sent;
	logic [3:0]              poll_recv;
	logic [3:0]              poll_sent_after;
	// PHY acked, waiting for the ack to fall
	logic                    pwr_done;
	logic                    lfps_idle;
	logic                    recov;

	assign lfps_idle = !lfps_send_req && !lfps_send_ack;
	assign recov = (ltssm_state == RECOVERY_ACTIVE) || (ltssm_state == RECOVERY_CONFIG) ||
		(ltssm_state == RECOVERY_IDLE);
	// LFPS listening only where a partner burst means something
	assign lfps_rx_enable = (ltssm_state == POLLING_LFPS) || (ltssm_state == U1);

	always_ff @(posedge slow_clk) begin
		ltssm_state_t nxt;
		ltssm_state_t fail;
		nxt = ltssm_state;
		// training timeout target
		fail = recov ? RX_DETECT_RESET : SS_DISABLED;
		if (hot_reset) begin
			ltssm_state <= RESET;
			dc <= '0;
			rx_tries <= '0;
			pwr_done <= 1'b0;
			partner_detect <= 1'b0;
			port_power_req <= 1'b0;
			port_power_down <= P2;
			lfps_send_req <= 1'b0;
			train_active <= 1'b0;
			train_config <= 1'b0;
			train_idle <= 1'b0;
		end else begin
			partner_detect <= 1'b0;
			// phase 3 of both handshakes, whatever the state
			if (lfps_send_req && lfps_send_ack)
				lfps_send_req <= 1'b0;
			if (port_power_req && port_power_ack)
				port_power_req <= 1'b0;

			//////////////////////////////////////////////////
			// state transitions
			//////////////////////////////////////////////////
			case (ltssm_state)
			RESET: nxt = RX_DETECT_RESET;
			RX_DETECT_RESET: begin
				rx_tries <= '0;
				nxt = RX_DETECT_ACTIVE;
			end
			RX_DETECT_ACTIVE: begin
				// detect pulse ends once the PHY is looking
				partner_detect <= !partner_looking;
				if (partner_looking)
					nxt = RX_DETECT_WAIT;
			end
			RX_DETECT_WAIT: begin
				if (!partner_looking) begin
					if (partner_detected) begin
						poll_sent <= '0;
						poll_recv <= '0;
						poll_sent_after <= '0;
						nxt = POLLING_LFPS;
					end else if (rx_tries == (`RX_DETECT_TRIES - 1)) begin
						nxt = SS_DISABLED;
					end else begin
						rx_tries <= rx_tries + 1'b1;
						nxt = RX_DETECT_QUIET;
					end
				end
			end
			RX_DETECT_QUIET: begin
				if (dc == `RX_DETECT_QUIET)
					nxt = RX_DETECT_ACTIVE;
			end
			POLLING_LFPS: begin
				if (lfps_recv_poll && ~&poll_recv)
					poll_recv <= poll_recv + 1'b1;
				// one cycle per completed burst
				if (lfps_send_req && lfps_send_ack) begin
					if (~&poll_sent)
						poll_sent <= poll_sent + 1'b1;
					if (poll_recv != '0 && ~&poll_sent_after)
						poll_sent_after <= poll_sent_after + 1'b1;
				end
				if (poll_sent >= `POLL_SENT_MIN && poll_recv >= `POLL_RECV_MIN &&
					poll_sent_after >= `POLL_SENT_AFTER_RECV)
					nxt = POLLING_P0;
				else if (dc == `T_POLLING_LFPS)
					nxt = SS_DISABLED;
				// keep bursts coming while we stay
				if (nxt == POLLING_LFPS && lfps_idle) begin
					lfps_send_req <= 1'b1;
					lfps_send_kind <= POLL;
				end
			end
			POLLING_P0, RECOVERY_P0, U1_ENTRY: begin
				// let a pending burst finish before the power change
				if (!pwr_done && !port_power_req && !port_power_ack && lfps_idle) begin
					port_power_req <= 1'b1;
					port_power_down <= (ltssm_state == U1_ENTRY) ? P1 : P0;
				end
				if (port_power_req && port_power_ack)
					pwr_done <= 1'b1;
				// advance on the falling ack
				if (pwr_done && !port_power_ack) begin
					tc <= '0;
					tsc <= '0;
					if (ltssm_state == U1_ENTRY)
						nxt = U1;
					else if (ltssm_state == POLLING_P0)
						nxt = POLLING_ACTIVE;
					else
						nxt = RECOVERY_ACTIVE;
				end
			end
			POLLING_ACTIVE, RECOVERY_ACTIVE: begin
				if (train_ts1 || train_ts2)
					tc <= tc + 1'b1;
				if (tc == `TS_RECV_COUNT) begin
					tc <= '0;
					nxt = recov ? RECOVERY_CONFIG : POLLING_CONFIG;
				end else if (dc == `T_TRAIN_STEP) begin
					nxt = fail;
				end
			end
			POLLING_CONFIG, RECOVERY_CONFIG: begin
				if (train_ts2 && tc != `TS_RECV_COUNT)
					tc <= tc + 1'b1;
				// send window opens with the first TS2 seen
				if (tc != '0 && tsc != `TS2_SEND_CYCLES)
					tsc <= tsc + 1'b1;
				if (tc == `TS_RECV_COUNT && tsc == `TS2_SEND_CYCLES)
					nxt = recov ? RECOVERY_IDLE : POLLING_IDLE;
				else if (dc == `T_TRAIN_STEP)
					nxt = fail;
			end
			POLLING_IDLE, RECOVERY_IDLE: begin
				if (train_idle_pass)
					nxt = U0;
				else if (dc == `T_TRAIN_STEP)
					nxt = fail;
			end
			U0: begin
				// partner TS1 in U0 means it went to recovery
				if (train_ts1 || go_recovery)
					nxt = RECOVERY_P0;
				else if (go_u1)
					nxt = U1_ENTRY;
			end
			U1: begin
				if (lfps_recv_u1_exit || go_recovery)
					nxt = ltssm_pkg::U1_EXIT;
			end
			ltssm_pkg::U1_EXIT: begin
				// single handshake burst, then retrain
				if (lfps_idle) begin
					lfps_send_req <= 1'b1;
					lfps_send_kind <= lfps_pkg::U1_EXIT;
				end
				if (lfps_send_req && lfps_send_ack)
					nxt = RECOVERY_P0;
			end
			SS_DISABLED: nxt = SS_DISABLED;
			default: nxt = RESET;
			endcase

			// link layer override
			if (go_disabled)
				nxt = SS_DISABLED;

			// timeout counter restarts on every state change
			if (nxt != ltssm_state) begin
				dc <= '0;
				pwr_done <= 1'b0;
			end else if (~&dc) begin
				dc <= dc + 1'b1;
			end
			ltssm_state <= nxt;
			train_active <= (nxt == POLLING_ACTIVE) || (nxt == RECOVERY_ACTIVE);
			train_config <= (nxt == POLLING_CONFIG) || (nxt == RECOVERY_CONFIG);
			train_idle <= (nxt == POLLING_IDLE) || (nxt == RECOVERY_IDLE);
		end
	end

endmodule

`default_nettype wire

// ==== src/ltssm_pkg.sv ====
/* link state and PHY power state types */
`default_nettype none

package ltssm_pkg;

	// link training states, RESET is the value after hot_reset
	typedef enum logic [4:0] {
		RESET,
		RX_DETECT_RESET,
		RX_DETECT_ACTIVE,
		RX_DETECT_WAIT,
		RX_DETECT_QUIET,
		POLLING_LFPS,
		POLLING_P0,
		POLLING_ACTIVE,
		POLLING_CONFIG,
		POLLING_IDLE,
		U0,
		U1_ENTRY,
		U1,
		U1_EXIT,
		RECOVERY_P0,
		RECOVERY_ACTIVE,
		RECOVERY_CONFIG,
		RECOVERY_IDLE,
		SS_DISABLED
	} ltssm_state_t;

	// PIPE power-down encoding
	typedef enum logic [1:0] {P0, P1, P2} power_down_t;

endpackage

`default_nettype wire

// ==== src/usb3_link_train.sv ====
/* top level, link training FSM with LFPS transmitter and receiver */
`default_nettype none

module usb3_link_train (
	input  logic                    slow_clk,
	input  logic                    hot_reset,
	input  logic                    partner_looking,
	input  logic                    partner_detected,
	// asynchronous, synchronized in lfps_rx
	input  logic                    port_rx_elecidle,
	input  logic                    port_power_ack,
	input  logic                    train_ts1,
	input  logic                    train_ts2,
	input  logic                    train_idle_pass,
	input  logic                    go_disabled,
	input  logic                    go_recovery,
	input  logic                    go_u1,
	output logic                    partner_detect,
	output logic                    port_tx_elecidle,
	output logic                    port_power_req,
	output ltssm_pkg::power_down_t  port_power_down,
	output logic                    train_active,
	output logic                    train_config,
	output logic                    train_idle,
	output ltssm_pkg::ltssm_state_t ltssm_state
);
	import lfps_pkg::*;

	// send handshake, controller to transmitter
	logic       lfps_send_req;
	lfps_kind_t lfps_send_kind;
	logic       lfps_send_ack;
	// receiver pulses and enable
	logic       lfps_recv_poll;
	logic       lfps_recv_u1_exit;
	logic       lfps_rx_enable;

	ltssm_ctrl u_ctrl (
		.slow_clk          (slow_clk),
		.hot_reset         (hot_reset),
		.partner_looking   (partner_looking),
		.partner_detected  (partner_detected),
		.port_power_ack    (port_power_ack),
		.train_ts1         (train_ts1),
		.train_ts2         (train_ts2),
		.train_idle_pass   (train_idle_pass),
		.go_disabled       (go_disabled),
		.go_recovery       (go_recovery),
		.go_u1             (go_u1),
		.lfps_send_ack     (lfps_send_ack),
		.lfps_recv_poll    (lfps_recv_poll),
		.lfps_recv_u1_exit (lfps_recv_u1_exit),
		.partner_detect    (partner_detect),
		.port_power_req    (port_power_req),
		.port_power_down   (port_power_down),
		.train_active      (train_active),
		.train_config      (train_config),
		.train_idle        (train_idle),
		.lfps_send_req     (lfps_send_req),
		.lfps_send_kind    (lfps_send_kind),
		.lfps_rx_enable    (lfps_rx_enable),
		.ltssm_state       (ltssm_state)
	);

	lfps_tx u_lfps_tx (
		.slow_clk         (slow_clk),
		.hot_reset        (hot_reset),
		.lfps_send_req    (lfps_send_req),
		.lfps_send_kind   (lfps_send_kind),
		.lfps_send_ack    (lfps_send_ack),
		.port_tx_elecidle (port_tx_elecidle)
	);

	lfps_rx u_lfps_rx (
		.slow_clk          (slow_clk),
		.hot_reset         (hot_reset),
		.port_rx_elecidle  (port_rx_elecidle),
		.lfps_rx_enable    (lfps_rx_enable),
		.lfps_recv_poll    (lfps_recv_poll),
		.lfps_recv_u1_exit (lfps_recv_u1_exit)
	);

endmodule

`default_nettype wire

// ==== verif/link_train_assert.sv ====
/* concurrent checks on the link training top level ports
   and the bind that attaches them to the DUT */
`default_nettype none
`include "ltssm_consts.svh"

module link_train_assert (
	input logic                    slow_clk,
	input logic                    hot_reset,
	input logic                    partner_detect,
	input logic                    port_tx_elecidle,
	input logic                    port_power_req,
	input logic                    port_power_ack,
	input ltssm_pkg::power_down_t  port_power_down,
	input logic                    train_active,
	input logic                    train_config,
	input logic                    train_idle,
	input logic                    train_idle_pass,
	input logic                    go_disabled,
	input ltssm_pkg::ltssm_state_t ltssm_state
);
	import ltssm_pkg::*;

	logic [7:0] det_count;
	logic       det_q;
	logic [7:0] low_len;
	logic       tx_q;
	logic [7:0] sent_cnt;

	//////////////////////////////////////////////////
	// helper counters
	//////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		det_q <= partner_detect;
		tx_q <= port_tx_elecidle;
		// detection pulses since the last detect restart
		if (hot_reset || ltssm_state == RX_DETECT_RESET)
			det_count <= '0;
		else if (partner_detect && !det_q)
			det_count <= det_count + 1'b1;
		// length of the current low period
		if (port_tx_elecidle)
			low_len <= '0;
		else
			low_len <= low_len + 1'b1;
		// polling bursts sent
		if (ltssm_state != POLLING_LFPS)
			sent_cnt <= '0;
		else if (!port_tx_elecidle && tx_q)
			sent_cnt <= sent_cnt + 1'b1;
	end

	// outputs quiet right after reset
	assert property (@(posedge slow_clk) hot_reset |=> (!port_power_req && !partner_detect &&
		!train_active && !train_config && !train_idle && port_tx_elecidle &&
		ltssm_state == RESET))
		else $error("outputs not idle after reset");

	// detect retries exhausted
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		($past(ltssm_state) == RX_DETECT_WAIT && ltssm_state == SS_DISABLED &&
		!$past(go_disabled)) |-> det_count == `RX_DETECT_TRIES)
		else $error("wrong number of detection pulses");
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		$past(ltssm_state) == SS_DISABLED |-> ltssm_state == SS_DISABLED)
		else $error("left SS_DISABLED without reset");

	// burst length by kind with U1 exit bursts only in U1_EXIT
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		(port_tx_elecidle && !tx_q) |-> low_len == ((ltssm_state == U1_EXIT) ?
		`LFPS_U1_EXIT_BURST : `LFPS_POLL_BURST))
		else $error("LFPS burst length wrong");
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		($past(ltssm_state) == POLLING_LFPS && ltssm_state == POLLING_P0) |->
		sent_cnt >= `POLL_SENT_MIN)
		else $error("polling left with too few bursts sent");

	// four-phase power handshake
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		$fell(port_power_req) |-> $past(port_power_ack))
		else $error("power request dropped before ack");
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		$rose(port_power_req) |-> !$past(port_power_ack))
		else $error("power request raised while ack high");
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		($past(port_power_req) && port_power_req) |-> $stable(port_power_down))
		else $error("power state moved during request");

	// P0 before each training run and P1 in U1
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		$rose(train_active) |-> port_power_down == P0)
		else $error("training started outside P0");
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		($past(ltssm_state) != U1 && ltssm_state == U1) |-> port_power_down == P1)
		else $error("U1 entered outside P1");

	// training step order
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		$onehot0({train_active, train_config, train_idle}))
		else $error("training outputs not one-hot");
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		$rose(train_config) |-> $past(train_active))
		else $error("config step without active step");
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		$rose(train_idle) |-> $past(train_config))
		else $error("idle step without config step");
	assert property (@(posedge slow_clk) disable iff (hot_reset)
		($past(ltssm_state) != U0 && ltssm_state == U0) |->
		($past(train_idle) && $past(train_idle_pass)))
		else $error("U0 entered without idle pass");

endmodule

bind usb3_link_train link_train_assert u_assert (
	.slow_clk         (slow_clk),
	.hot_reset        (hot_reset),
	.partner_detect   (partner_detect),
	.port_tx_elecidle (port_tx_elecidle),
	.port_power_req   (port_power_req),
	.port_power_ack   (port_power_ack),
	.port_power_down  (port_power_down),
	.train_active     (train_active),
	.train_config     (train_config),
	.train_idle       (train_idle),
	.train_idle_pass  (train_idle_pass),
	.go_disabled      (go_disabled),
	.ltssm_state      (ltssm_state)
);

`default_nettype wire

// ==== verif/tb_clock.sv ====
/* testbench clock source, period 100 */
`default_nettype none

module tb_clock (
	output logic slow_clk
);

	// half period of 50
	initial slow_clk = 1'b0;
	always #50 slow_clk = ~slow_clk;

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
/* testbench top with the DUT, link partner and PHY model, LFSR, scenarios,
   watchdog and closing report */
`default_nettype none
`include "ltssm_consts.svh"

module tb_top;
	import ltssm_pkg::*;

	// scenario lengths in cycles
	localparam int DETECT_CYCLES = `RX_DETECT_TRIES * (`RX_DETECT_QUIET + 12) + 100;
	localparam int TRAIN_CYCLES = `T_POLLING_LFPS + 8 * `T_TRAIN_STEP + 400;
	localparam int MARGIN = 500;

	logic         slow_clk;
	logic         hot_reset;
	logic         partner_looking;
	logic         partner_detected;
	logic         port_rx_elecidle;
	logic         port_power_ack;
	logic         train_ts1;
	logic         train_ts2;
	logic         train_idle_pass;
	logic         go_disabled;
	logic         go_recovery;
	logic         go_u1;
	logic         partner_detect;
	logic         port_tx_elecidle;
	logic         port_power_req;
	power_down_t  port_power_down;
	logic         train_active;
	logic         train_config;
	logic         train_idle;
	ltssm_state_t ltssm_state;
	logic [15:0]  lfsr;
	int           state_errors;
	int           timeouts;

	tb_clock u_clock (.slow_clk(slow_clk));

	usb3_link_train DUT (.*);

	// galois LFSR with taps 16 14 13 11, one step per bit taken
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic apply_reset();
		@(posedge slow_clk);
		hot_reset <= 1'b1;
		repeat (4) @(posedge slow_clk);
		hot_reset <= 1'b0;
	endtask

	task automatic wait_for_state(input ltssm_state_t target, input int limit);
		int n;
		n = 0;
		while (ltssm_state !== target && n < limit) begin
			@(negedge slow_clk);
			n++;
		end
		if (ltssm_state !== target) begin
			$display("timed out waiting for state %s", target.name());
			timeouts++;
		end
	endtask

	task automatic check_state(input ltssm_state_t exp);
		@(negedge slow_clk);
		if (ltssm_state !== exp) begin
			$display("Error at %0t: ltssm_state expected %s got %s", $time, exp.name(),
				ltssm_state.name());
			state_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// partner and PHY model
	//////////////////////////////////////////////////
	always @(posedge slow_clk) begin
		partner_looking <= partner_detect;
		// TS2 every other cycle while training runs
		train_ts2 <= (train_active || train_config) && !train_ts2;
		train_idle_pass <= train_idle && !train_idle_pass;
	end

	// four-phase power ack with random latency
	initial begin
		int d;
		forever begin
			@(posedge slow_clk);
			if (port_power_req && !port_power_ack) begin
				d = take_bits(3);
				repeat (d) @(posedge slow_clk);
				port_power_ack <= 1'b1;
				do @(posedge slow_clk); while (port_power_req);
				d = take_bits(3);
				repeat (d) @(posedge slow_clk);
				port_power_ack <= 1'b0;
			end
		end
	end

	// polling bursts 16 cycles apart start to start
	initial begin
		int v;
		forever begin
			@(posedge slow_clk);
			while (ltssm_state == POLLING_LFPS) begin
				v = take_bits(2);
				port_rx_elecidle <= 1'b0;
				repeat (`POLL_RX_MIN + v % 3) @(posedge slow_clk);
				port_rx_elecidle <= 1'b1;
				repeat (16 - `POLL_RX_MIN - v % 3) @(posedge slow_clk);
			end
		end
	end

	//////////////////////////////////////////////////
	// scenarios
	//////////////////////////////////////////////////
	initial begin
		lfsr = 16'd52;
		state_errors = 0;
		timeouts = 0;
		hot_reset <= 1'b1;
		partner_looking <= 1'b0;
		partner_detected <= 1'b0;
		port_rx_elecidle <= 1'b1;
		port_power_ack <= 1'b0;
		train_ts1 <= 1'b0;
		train_ts2 <= 1'b0;
		train_idle_pass <= 1'b0;
		go_disabled <= 1'b0;
		go_recovery <= 1'b0;
		go_u1 <= 1'b0;
		repeat (4) @(posedge slow_clk);
		hot_reset <= 1'b0;

		// no partner so the retries run out
		wait_for_state(SS_DISABLED, DETECT_CYCLES);
		repeat (50) @(posedge slow_clk);
		check_state(SS_DISABLED);

		// partner present and full training to U0
		@(posedge slow_clk);
		partner_detected <= 1'b1;
		apply_reset();
		wait_for_state(U0, TRAIN_CYCLES);
		check_state(U0);

		// U1 entry then a partner exit burst
		@(posedge slow_clk);
		go_u1 <= 1'b1;
		@(posedge slow_clk);
		go_u1 <= 1'b0;
		wait_for_state(U1, 200);
		@(posedge slow_clk);
		port_rx_elecidle <= 1'b0;
		repeat (`U1_EXIT_RX_MIN + 3) @(posedge slow_clk);
		port_rx_elecidle <= 1'b1;
		wait_for_state(RECOVERY_P0, 100);
		wait_for_state(U0, TRAIN_CYCLES);
		check_state(U0);

		repeat (5) @(posedge slow_clk);
		$display("errors: state %0d, timeout %0d", state_errors, timeouts);
		if (state_errors == 0 && timeouts == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// watchdog over all scenarios
	initial begin
		#((DETECT_CYCLES + 2 * TRAIN_CYCLES + 300 + MARGIN) * 100);
		$display("watchdog expired, the simulation ran far longer than its scenarios");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/ltssm_pkg.sv
src/lfps_pkg.sv
src/lfps_tx.sv
src/lfps_rx.sv
src/ltssm_ctrl.sv
src/usb3_link_train.sv
verif/tb_clock.sv
verif/link_train_assert.sv
verif/tb_top.sv
